// ==== pingPongTest.f ====
hw/pingPongPkg.sv
hw/lineWriter.sv
hw/notifyDetect.sv
hw/lineReader.sv
hw/pingPongTest.sv
verif/hostModel.sv
verif/pingPongTb.sv

// ==== runSim.sh ====
#!/bin/sh
# build and run the ping-pong testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module pingPongTb \
   -f pingPongTest.f -o pingPongSim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/pingPongSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -qx "Test completed successfully"; then
   exit 0
fi
exit 1

// ==== verif/pingPongTb.sv ====
/*
 * Testbench top for the ping-pong latency test. Runs CSR, UMsg, poll,
 * error-injection and zero-line runs against hostModel, checks every write,
 * read and completion against the cache-line rules and prints a summary.
 */
`timescale 1ns/1ps

module pingPongTb;

   localparam int runLines [6] = '{8, 8, 8, 8, 8, 0};   // N per run which also sizes the watchdog

   logic                    Clk_400;
   logic                    reset;
   logic                    go;
   pingPongPkg::countT      lineCount;
   pingPongPkg::notifyModeT notifyMode;
   logic                    corruptEn;
   pingPongPkg::addrT       corruptAddr;
   logic                    csrWrite, umsgValid, notified;
   logic                    writeEn, writeFence, writeSent;
   pingPongPkg::addrT       writeAddr;
   pingPongPkg::lineT       writeData;
   logic                    readEn, readSent, readRspValid;
   pingPongPkg::addrT       readAddr, readRspAddr;
   pingPongPkg::lineT       readData;
   pingPongPkg::hdrT        readRspHdr;
   logic                    testCmp, errorValid;

   int   mismatches = 0;
   int   failures   = 0;
   int   wrStep;                  // accepted writes this run
   int   rdNext;                  // next expected data read
   int   pollReads;
   int   rspCount;                // data responses seen
   logic flagWritten, badRspSeen, errSeen, cmpSeen;

   pingPongTest dut
   (
      .Clk_400 (Clk_400), .reset (reset), .go (go), .lineCount (lineCount),
      .notifyMode (notifyMode), .csrWrite (csrWrite), .umsgValid (umsgValid),
      .writeEn (writeEn), .writeFence (writeFence), .writeAddr (writeAddr),
      .writeData (writeData), .writeSent (writeSent), .readEn (readEn),
      .readAddr (readAddr), .readSent (readSent), .readRspValid (readRspValid),
      .readRspAddr (readRspAddr), .readData (readData), .readRspHdr (readRspHdr),
      .testCmp (testCmp), .errorValid (errorValid)
   );

   hostModel host
   (
      .Clk_400 (Clk_400), .reset (reset), .notifyMode (notifyMode),
      .lineCount (lineCount), .corruptEn (corruptEn), .corruptAddr (corruptAddr),
      .writeEn (writeEn), .writeFence (writeFence), .writeAddr (writeAddr),
      .writeData (writeData), .writeSent (writeSent), .readEn (readEn),
      .readAddr (readAddr), .readSent (readSent), .readRspValid (readRspValid),
      .readRspAddr (readRspAddr), .readData (readData), .readRspHdr (readRspHdr),
      .csrWrite (csrWrite), .umsgValid (umsgValid), .notified (notified)
   );

   initial
   begin
      Clk_400 = 1'b0;
      forever #50 Clk_400 = ~Clk_400;
   end

   // ************************************************************
   // reference model and reporting
   // ************************************************************
   // data lines hold word 1 everywhere with the address in the low 17 bits
   // flag line has the low 64 bits set and the rest clear
   function automatic pingPongPkg::lineT expectedLine(input pingPongPkg::addrT addr,
                                                      input logic isFlag);
      pingPongPkg::lineT line;
      line = '0;
      if (isFlag)
         line[63:0] = {64{1'b1}};
      else
      begin
         for (int w = 0; w < 16; w++)
            line[w*32 +: 32] = 32'h0000_0001;
         line[16:0] = addr[16:0];
      end
      return line;
   endfunction

   // step number of the flag write with no fence when N is 0
   function automatic int flagStep();
      return (lineCount != '0) ? int'(lineCount) + 1 : 0;
   endfunction

   task automatic reportMismatch(input string msg);
      mismatches++;
      $display("mismatch at %0t: %s", $time, msg);
   endtask

   task automatic reportFailure(input string msg);
      failures++;
      $display("error at %0t: %s", $time, msg);
   endtask

   task automatic checkWrite();
      int n;
      n = int'(lineCount);
      assert (wrStep <= flagStep())
      else reportFailure("write accepted after the flag line");
      if (wrStep < n)
         assert (writeEn && !writeFence && writeAddr == pingPongPkg::addrT'(wrStep)
                 && writeData == expectedLine(pingPongPkg::addrT'(wrStep), 1'b0))
         else reportMismatch($sformatf("write %0d: en %b fence %b addr %0d data %h",
                             wrStep, writeEn, writeFence, writeAddr, writeData[63:0]));
      else if (wrStep < flagStep())
         assert (writeFence && !writeEn)
         else reportMismatch($sformatf("write %0d should be the fence, en %b fence %b",
                             wrStep, writeEn, writeFence));
      else if (wrStep == flagStep())
      begin
         assert (writeEn && writeAddr == pingPongPkg::addrT'(n)
                 && writeData == expectedLine(pingPongPkg::addrT'(n), 1'b1))
         else reportMismatch($sformatf("flag write: addr %0d data %h",
                             writeAddr, writeData[63:0]));
         flagWritten = 1'b1;
      end
      wrStep++;
   endtask

   task automatic checkRead();
      if (notifyMode == pingPongPkg::notifyPoll && pingPongPkg::countT'(readAddr) == lineCount)
      begin
         pollReads++;
         assert (rdNext == 0) else reportFailure("flag poll issued after data reads began");
      end
      else
      begin
         assert (readAddr == pingPongPkg::addrT'(rdNext) && rdNext < int'(lineCount))
         else reportMismatch($sformatf("read %0d at address %0d", rdNext, readAddr));
         if (notifyMode == pingPongPkg::notifyPoll)
            assert (pollReads == 3)
            else reportFailure("data read issued before the flag word was seen");
         rdNext++;
      end
   endtask

   // ************************************************************
   // comparing process
   // ************************************************************
   always @(posedge Clk_400)
   begin
      if (reset)
      begin
         wrStep      = 0;
         rdNext      = 0;
         pollReads   = 0;
         rspCount    = 0;
         flagWritten = 1'b0;
         badRspSeen  = 1'b0;
         errSeen     = 1'b0;
         cmpSeen     = 1'b0;
      end
      else
      begin
         if (writeSent && (writeEn || writeFence))
            checkWrite();
         if (readSent && readEn)
            checkRead();
         if (readEn && notifyMode != pingPongPkg::notifyPoll)
            assert (notified) else reportFailure("readEn raised before the host notification");
         if (readRspValid && pingPongPkg::countT'(readRspAddr) < lineCount)
         begin
            rspCount++;
            if (corruptEn && readRspAddr == corruptAddr)
               badRspSeen = 1'b1;
         end
         // errorValid is sticky and only after the bad response
         if (corruptEn)
         begin
            assert (!errorValid || badRspSeen)
            else reportMismatch("errorValid set before the corrupted response");
            assert (errorValid || !errSeen) else reportMismatch("errorValid dropped before reset");
            errSeen = errSeen || errorValid;
         end
         else
            assert (!errorValid) else reportMismatch("errorValid set in a clean run");
         if (testCmp && !cmpSeen)
         begin
            cmpSeen = 1'b1;
            assert (rspCount == int'(lineCount))
            else reportFailure($sformatf("testCmp after %0d of %0d read responses",
                               rspCount, lineCount));
            assert (flagWritten) else reportFailure("testCmp rose before the flag write");
            assert (notifyMode == pingPongPkg::notifyPoll || notified)
            else reportFailure("testCmp rose before the host notification");
            assert (wrStep == flagStep() + 1)
            else reportFailure($sformatf("%0d writes accepted before testCmp", wrStep));
            assert (rdNext == int'(lineCount))
            else reportFailure($sformatf("%0d data reads issued before testCmp", rdNext));
            assert (notifyMode != pingPongPkg::notifyPoll || pollReads == 3)
            else reportFailure($sformatf("expected three flag polls, saw %0d", pollReads));
            assert (!corruptEn || errorValid)
            else reportFailure("errorValid not set after the corrupted response");
         end
      end
   end

   // ************************************************************
   // run sequence
   // ************************************************************
   task automatic runTest(input int n, input pingPongPkg::notifyModeT mode, input logic corrupt);
      @(posedge Clk_400);
      reset      <= 1'b1;
      lineCount  <= n;
      notifyMode <= mode;
      corruptEn  <= corrupt;
      repeat (2) @(posedge Clk_400);
      reset <= 1'b0;
      @(posedge Clk_400);
      go <= 1'b1;                              // single-cycle start
      @(posedge Clk_400);
      go <= 1'b0;
      while (testCmp !== 1'b1)
         @(posedge Clk_400);
      repeat (4) @(posedge Clk_400);           // errorValid must hold
   endtask

   initial
   begin
      reset       = 1'b1;
      go          = 1'b0;
      lineCount   = '0;
      notifyMode  = pingPongPkg::notifyCsr;
      corruptEn   = 1'b0;
      corruptAddr = 20'd5;
      runTest(runLines[0], pingPongPkg::notifyCsr, 1'b0);
      runTest(runLines[1], pingPongPkg::notifyUmsgData, 1'b0);
      runTest(runLines[2], pingPongPkg::notifyUmsgHint, 1'b0);
      runTest(runLines[3], pingPongPkg::notifyPoll, 1'b0);
      runTest(runLines[4], pingPongPkg::notifyCsr, 1'b1);   // one bad response
      runTest(runLines[5], pingPongPkg::notifyCsr, 1'b0);   // flag only
      $display("runs 6, mismatches %0d, other errors %0d", mismatches, failures);
      if (mismatches == 0 && failures == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   // watchdog allows 40 cycles per line plus setup slack
   initial
   begin
      int limit;
      limit = 2000;
      foreach (runLines[i])
         limit += runLines[i] * 40;
      repeat (limit) @(posedge Clk_400);
      $display("watchdog expired after %0d cycles, a run never reached testCmp", limit);
      $display("Test failed");
      $finish;
   end

endmodule

// ==== verif/hostModel.sv ====
/*
 * Host-side model for the ping-pong testbench. Takes writes and reads with
 * LFSR-driven accept strobes, returns read data through a 3-stage pipeline,
 * answers the flag polls, sends the configured notification and can corrupt
 * one data response.
 */
`timescale 1ns/1ps

module hostModel
(
   input  logic                      Clk_400,
   input  logic                      reset,
   input  pingPongPkg::notifyModeT   notifyMode,
   input  pingPongPkg::countT        lineCount,
   input  logic                      corruptEn,      // flip bits in one response
   input  pingPongPkg::addrT         corruptAddr,
   input  logic                      writeEn,
   input  logic                      writeFence,
   input  pingPongPkg::addrT         writeAddr,
   input  pingPongPkg::lineT         writeData,
   output logic                      writeSent,
   input  logic                      readEn,
   input  pingPongPkg::addrT         readAddr,
   output logic                      readSent,
   output logic                      readRspValid,
   output pingPongPkg::addrT         readRspAddr,
   output pingPongPkg::lineT         readData,
   output pingPongPkg::hdrT          readRspHdr,     // rsp header or umsg header
   output logic                      csrWrite,
   output logic                      umsgValid,
   output logic                      notified        // qualifying notification sent
);

   pingPongPkg::lineT mem [0:63];
   pingPongPkg::lineT stageData [0:1];
   pingPongPkg::addrT stageAddr [0:1];
   logic              stageValid [0:1];
   pingPongPkg::lineT rspData;
   logic [31:0]       lfsr = 32'hba99_5c67;
   logic [31:0]       lfsrMid;
   logic              writeBit;
   logic              readBit;
   logic              pollAtFlag;       // read of the flag line in poll mode
   logic              wantHint;
   int                pollCount;
   int                notifyTimer;

   // galois lfsr with taps x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsrStep(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   initial
   begin
      for (int i = 0; i < 64; i++)
         mem[i] = {16{32'hc0de_0000 + i}};   // never-written lines are recognizable
      writeSent    = 1'b0;
      readSent     = 1'b0;
      readRspValid = 1'b0;
      readRspAddr  = '0;
      readData     = '0;
      readRspHdr   = '0;
      csrWrite     = 1'b0;
      umsgValid    = 1'b0;
      notified     = 1'b0;
   end

   // one lfsr bit per strobe and two bits a cycle
   assign writeBit   = lfsr[0];
   assign lfsrMid    = lfsrStep(lfsr);
   assign readBit    = lfsrMid[0];
   assign wantHint   = (notifyMode == pingPongPkg::notifyUmsgHint);
   assign pollAtFlag = (notifyMode == pingPongPkg::notifyPoll)
                       && (pingPongPkg::countT'(readAddr) == lineCount);

   always_comb
   begin
      rspData = mem[readAddr[5:0]];
      if (pollAtFlag && pollCount < 2)
         rspData[63:32] = '0;                      // first two polls see no flag
      if (corruptEn && readAddr == corruptAddr)
         rspData[15:0] = rspData[15:0] ^ 16'h0040;
   end

   // ************************************************************
   // accept strobes, memory, notification, response pipeline
   // ************************************************************
   always @(posedge Clk_400)
   begin
      lfsr       <= lfsrStep(lfsrMid);
      csrWrite   <= 1'b0;
      umsgValid  <= 1'b0;
      readRspHdr <= '0;
      if (reset)
      begin
         writeSent     <= 1'b0;
         readSent      <= 1'b0;
         readRspValid  <= 1'b0;
         stageValid[0] <= 1'b0;
         stageValid[1] <= 1'b0;
         notified      <= 1'b0;
         pollCount     <= 0;
         notifyTimer   <= 0;
      end
      else
      begin
         writeSent <= !writeSent && (writeEn || writeFence) && writeBit;   // never twice in a row
         readSent  <= !readSent && readEn && readBit;
         if (writeSent && writeEn)
         begin
            mem[writeAddr[5:0]] <= writeData;
            if (pingPongPkg::countT'(writeAddr) == lineCount
                && notifyMode != pingPongPkg::notifyPoll)
               notifyTimer <= 12;                  // flag is in so notify a bit later
         end
         else if (notifyTimer != 0)
            notifyTimer <= notifyTimer - 1;

         // two decoy umsgs go out first
         if (notifyTimer == 9)
         begin
            umsgValid  <= 1'b1;
            readRspHdr <= {wantHint, 12'h000, 3'b101};   // nonzero id
         end
         if (notifyTimer == 6)
         begin
            umsgValid  <= 1'b1;
            readRspHdr <= {!wantHint, 15'h0000};          // wrong flavor
         end
         if (notifyTimer == 2)
         begin
            notified <= 1'b1;
            $display("host: %s notification at %0t", notifyMode.name(), $time);
            if (notifyMode == pingPongPkg::notifyCsr)
               csrWrite <= 1'b1;
            else
            begin
               umsgValid  <= 1'b1;
               readRspHdr <= {wantHint, 15'h0000};
            end
         end

         // responses in request order
         stageValid[0] <= readSent && readEn;
         stageAddr[0]  <= readAddr;
         stageData[0]  <= rspData;
         stageValid[1] <= stageValid[0];
         stageAddr[1]  <= stageAddr[0];
         stageData[1]  <= stageData[0];
         readRspValid  <= stageValid[1];
         readRspAddr   <= stageAddr[1];
         readData      <= stageData[1];
         if (readSent && readEn && pollAtFlag)
            pollCount <= pollCount + 1;
      end
   end

endmodule

// ==== hw/pingPongTest.sv ====
/*
 * Top level of the ping-pong latency test. Connects the write engine, the
 * notification detector and the read engine to the host-facing ports.
 * testCmp marks the end of a run.
 */
`timescale 1ns/1ps

module pingPongTest
(
   input  logic                      Clk_400,
   input  logic                      reset,

   // test control
   input  logic                      go,
   input  pingPongPkg::countT        lineCount,
   input  pingPongPkg::notifyModeT   notifyMode,
   input  logic                      csrWrite,
   input  logic                      umsgValid,

   // write port
   output logic                      writeEn,
   output logic                      writeFence,
   output pingPongPkg::addrT         writeAddr,
   output pingPongPkg::lineT         writeData,
   input  logic                      writeSent,

   // read port and responses
   output logic                      readEn,
   output pingPongPkg::addrT         readAddr,
   input  logic                      readSent,
   input  logic                      readRspValid,
   input  pingPongPkg::addrT         readRspAddr,
   input  pingPongPkg::lineT         readData,
   input  pingPongPkg::hdrT          readRspHdr,   // also umsg header

   // status
   output logic                      testCmp,
   output logic                      errorValid
);

   logic              writeDone;
   logic              pollReq;
   pingPongPkg::addrT pollAddr;
   logic              pollSent;
   logic              readGo;

   lineWriter writer
   (
      .Clk_400    (Clk_400),
      .reset      (reset),
      .go         (go),
      .lineCount  (lineCount),
      .writeSent  (writeSent),
      .writeEn    (writeEn),
      .writeFence (writeFence),
      .writeAddr  (writeAddr),
      .writeData  (writeData),
      .writeDone  (writeDone)
   );

   notifyDetect notify
   (
      .Clk_400      (Clk_400),
      .reset        (reset),
      .notifyMode   (notifyMode),
      .lineCount    (lineCount),
      .writeDone    (writeDone),
      .csrWrite     (csrWrite),
      .umsgValid    (umsgValid),
      .readRspValid (readRspValid),
      .readData     (readData),
      .readRspHdr   (readRspHdr),
      .pollSent     (pollSent),
      .pollReq      (pollReq),
      .pollAddr     (pollAddr),
      .readGo       (readGo)
   );

   lineReader reader
   (
      .Clk_400      (Clk_400),
      .reset        (reset),
      .lineCount    (lineCount),
      .readGo       (readGo),
      .writeDone    (writeDone),
      .pollReq      (pollReq),
      .pollAddr     (pollAddr),
      .readSent     (readSent),
      .readRspValid (readRspValid),
      .readRspAddr  (readRspAddr),
      .readData     (readData),
      .readEn       (readEn),
      .readAddr     (readAddr),
      .pollSent     (pollSent),
      .testCmp      (testCmp),
      .errorValid   (errorValid)
   );

endmodule

// ==== hw/lineReader.sv ====
/*
 * Read-phase engine. Owns the read port and carries the flag-poll reads on it
 * while idle. After readGo it reads lines 0..N-1, counts the responses, checks
 * each response's data against its address and raises testCmp at the end.
 */
`timescale 1ns/1ps

module lineReader
(
   input  logic                 Clk_400,
   input  logic                 reset,
   input  pingPongPkg::countT   lineCount,
   input  logic                 readGo,        // host notification seen
   input  logic                 writeDone,
   input  logic                 pollReq,       // flag poll from notifyDetect
   input  pingPongPkg::addrT    pollAddr,
   input  logic                 readSent,
   input  logic                 readRspValid,
   input  pingPongPkg::addrT    readRspAddr,
   input  pingPongPkg::lineT    readData,

   output logic                 readEn,
   output pingPongPkg::addrT    readAddr,
   output logic                 pollSent,
   output logic                 testCmp,
   output logic                 errorValid
);

   pingPongPkg::readStateT readState;
   pingPongPkg::addrT      reqAddr;       // next data line to read
   pingPongPkg::countT     rspCount;      // data responses so far
   logic                   lastReq;
   logic                   readPhase;     // read or response-wait

   // check pipeline
   logic                                 rspValidQ;
   logic [pingPongPkg::checkBits-1:0]    rspAddrQ;
   logic [pingPongPkg::checkBits-1:0]    rspDataQ;

   assign lastReq   = (pingPongPkg::countT'(reqAddr) + 32'd1) == lineCount;
   assign readPhase = (readState == pingPongPkg::rdRead) || (readState == pingPongPkg::rdResp);

   // poll requests ride the read port only while idle
   always_comb
   begin
      if (readState == pingPongPkg::rdWait)
      begin
         readEn   = pollReq;
         readAddr = pollAddr;
      end
      else
      begin
         readEn   = (readState == pingPongPkg::rdRead);
         readAddr = reqAddr;
      end
   end

   assign pollSent = readSent && (readState == pingPongPkg::rdWait);

   // ************************************************************
   // read FSM and response counter
   // ************************************************************
   always_ff @(posedge Clk_400)
   begin
      if (reset)
      begin
         readState <= pingPongPkg::rdWait;
         reqAddr   <= '0;
         rspCount  <= '0;
      end
      else
      begin
         if (readPhase && readRspValid)
            rspCount <= rspCount + 1'b1;
         case (readState)
            pingPongPkg::rdWait:
            begin
               reqAddr  <= '0;
               rspCount <= '0;   // poll responses do not count
               if (readGo)
               begin
                  if (lineCount != '0)
                     readState <= pingPongPkg::rdRead;
                  else
                     readState <= pingPongPkg::rdDone;
               end
            end
            pingPongPkg::rdRead:
            begin
               if (readSent)
               begin
                  reqAddr <= reqAddr + 1'b1;
                  if (lastReq)
                     readState <= pingPongPkg::rdResp;
               end
            end
            pingPongPkg::rdResp:
            begin
               if (rspCount == lineCount)
                  readState <= pingPongPkg::rdDone;   // all completions in
            end
            default:
            begin
               readState <= pingPongPkg::rdDone;
            end
         endcase
      end
   end

   // ************************************************************
   // data check one cycle behind the response
   // ************************************************************
   always_ff @(posedge Clk_400)
   begin
      rspAddrQ <= readRspAddr[pingPongPkg::checkBits-1:0];
      rspDataQ <= readData[pingPongPkg::checkBits-1:0];
   end

   always_ff @(posedge Clk_400)
   begin
      if (reset)
      begin
         rspValidQ  <= 1'b0;
         errorValid <= 1'b0;
         testCmp    <= 1'b0;
      end
      else
      begin
         rspValidQ <= readRspValid && readPhase;
         if (rspValidQ && rspDataQ != rspAddrQ)
            errorValid <= 1'b1;   // sticky until reset
         testCmp <= writeDone && (readState == pingPongPkg::rdDone);
      end
   end

endmodule

// ==== hw/notifyDetect.sv ====
/*
 * Host notification detector. Depending on notifyMode it polls the flag line,
 * waits for a CSR write, or waits for a UMsg with the right hint bit and a
 * zero ID, and then signals readGo to the line reader.
 */
`timescale 1ns/1ps

module notifyDetect
(
   input  logic                      Clk_400,
   input  logic                      reset,
   input  pingPongPkg::notifyModeT   notifyMode,    // static
   input  pingPongPkg::countT        lineCount,     // flag sits at address N
   input  logic                      writeDone,     // flag line has been written
   input  logic                      csrWrite,      // one-cycle pulse
   input  logic                      umsgValid,
   input  logic                      readRspValid,
   input  pingPongPkg::lineT         readData,
   input  pingPongPkg::hdrT          readRspHdr,
   input  logic                      pollSent,      // poll read taken by host

   output logic                      pollReq,
   output pingPongPkg::addrT         pollAddr,
   output logic                      readGo
);

   pingPongPkg::pollStateT pollState;
   logic                   flagSeen;      // polled flag word is set
   logic                   umsgHit;       // qualifying umsg this cycle
   logic                   wantHint;

   assign pollAddr = lineCount[pingPongPkg::addrWidth-1:0];
   assign pollReq  = (pollState == pingPongPkg::pollRead);

   assign flagSeen = readRspValid && (readData[63:32] == pingPongPkg::flagReadyWord);

   // hint bit must match the configured umsg flavor
   assign wantHint = (notifyMode == pingPongPkg::notifyUmsgHint);
   assign umsgHit  = umsgValid
                     && (readRspHdr[pingPongPkg::umsgHintBit] == wantHint)
                     && (readRspHdr[pingPongPkg::umsgIdBits-1:0] == '0);

   // ************************************************************
   // flag poll FSM
   // ************************************************************
   always_ff @(posedge Clk_400)
   begin
      if (reset)
         pollState <= pingPongPkg::pollWait;
      else
      begin
         case (pollState)
            pingPongPkg::pollWait:
            begin
               if (writeDone && notifyMode == pingPongPkg::notifyPoll)
                  pollState <= pingPongPkg::pollRead;
            end
            pingPongPkg::pollRead:
            begin
               if (pollSent)
                  pollState <= pingPongPkg::pollResp;
            end
            pingPongPkg::pollResp:
            begin
               // only one poll in flight, so any response is ours
               if (flagSeen)
                  pollState <= pingPongPkg::pollDone;
               else if (readRspValid)
                  pollState <= pingPongPkg::pollRead;   // not ready yet so ask again
            end
            default:
            begin
               pollState <= pingPongPkg::pollDone;
            end
         endcase
      end
   end

   // ************************************************************
   // read go
   // ************************************************************
   always_ff @(posedge Clk_400)
   begin
      if (reset)
         readGo <= 1'b0;
      else
      begin
         case (notifyMode)
            pingPongPkg::notifyPoll:
               readGo <= readGo || (pollState == pingPongPkg::pollResp && flagSeen);  // held
            pingPongPkg::notifyCsr:
               readGo <= csrWrite;
            default:
               readGo <= umsgHit;   // both umsg modes
         endcase
      end
   end

endmodule

// ==== hw/lineWriter.sv ====
/*
 * Write-phase engine. After go it writes N data lines tagged with their
 * address, then a write fence, then the flag line at address N, and holds
 * writeDone once the flag has been taken by the host.
 */
`timescale 1ns/1ps

module lineWriter
(
   input  logic                 Clk_400,
   input  logic                 reset,
   input  logic                 go,            // start pulse from host
   input  pingPongPkg::countT   lineCount,     // N, static during a run
   input  logic                 writeSent,     // host took the request

   output logic                 writeEn,
   output logic                 writeFence,
   output pingPongPkg::addrT    writeAddr,
   output pingPongPkg::lineT    writeData,
   output logic                 writeDone
);

   pingPongPkg::writeStateT writeState;
   logic                    lastLine;          // current data line is line N-1

   assign lastLine = (pingPongPkg::countT'(writeAddr) + 32'd1) == lineCount;

   // ************************************************************
   // write FSM
   // ************************************************************
   always_ff @(posedge Clk_400)
   begin
      if (reset)
      begin
         writeState <= pingPongPkg::wrWait;
         writeAddr  <= '0;
      end
      else
      begin
         case (writeState)
            pingPongPkg::wrWait:
            begin
               writeAddr <= '0;
               if (go)
               begin
                  // no data lines means the flag goes out at address 0
                  if (lineCount != '0)
                     writeState <= pingPongPkg::wrWrite;
                  else
                     writeState <= pingPongPkg::wrFlag;
               end
            end
            pingPongPkg::wrWrite:
            begin
               if (writeSent)
               begin
                  writeAddr <= writeAddr + 1'b1;   // ends at N for the flag
                  if (lastLine)
                     writeState <= pingPongPkg::wrFence;
               end
            end
            pingPongPkg::wrFence:
            begin
               if (writeSent)
                  writeState <= pingPongPkg::wrFlag;
            end
            pingPongPkg::wrFlag:
            begin
               if (writeSent)
                  writeState <= pingPongPkg::wrDone;
            end
            default:
            begin
               writeState <= pingPongPkg::wrDone;   // hold until reset
            end
         endcase
      end
   end

   // request strobes straight from state
   assign writeEn    = (writeState == pingPongPkg::wrWrite) || (writeState == pingPongPkg::wrFlag);
   assign writeFence = (writeState == pingPongPkg::wrFence);
   assign writeDone  = (writeState == pingPongPkg::wrDone);

   // data line is the fill pattern with the address in the low bits
   always_comb
   begin
      if (writeState == pingPongPkg::wrFlag)
         writeData = pingPongPkg::flagLine;
      else
      begin
         writeData = {(pingPongPkg::lineWidth/32){pingPongPkg::fillWord}};
         writeData[pingPongPkg::addrTagBits-1:0] = writeAddr[pingPongPkg::addrTagBits-1:0];
      end
   end

endmodule

// ==== hw/pingPongPkg.sv ====
/*
 * Shared widths, line patterns and state encodings for the host/accelerator
 * ping-pong latency test. Every RTL and testbench file refers to these by
 * scoped name, so the package compiles first.
 */
package pingPongPkg;

   localparam int addrWidth = 20;                   // cache-line address bits
   localparam int lineWidth = 512;                  // one cache line

   typedef logic [addrWidth-1:0] addrT;
   typedef logic [lineWidth-1:0] lineT;
   typedef logic [31:0]          countT;            // line count from host
   typedef logic [15:0]          hdrT;              // read rsp / umsg header

   // ************************************************************
   // line patterns
   // ************************************************************
   localparam logic [31:0] fillWord      = 32'h0000_0001;   // repeated over data lines
   localparam int          addrTagBits   = 17;              // low bits carry the address
   localparam lineT        flagLine      = {{(lineWidth-64){1'b0}}, {64{1'b1}}};
   localparam logic [31:0] flagReadyWord = 32'hffff_ffff;   // host sets flag bits 63:32
   localparam int          checkBits     = 16;              // compared on readback

   // umsg header fields
   localparam int umsgHintBit = 15;                 // 0 = umsg with data, 1 = hint
   localparam int umsgIdBits  = 3;                  // id must be zero

   // ************************************************************
   // encodings
   // ************************************************************
   typedef enum logic [1:0] {notifyPoll, notifyCsr, notifyUmsgData, notifyUmsgHint} notifyModeT;
   typedef enum logic [2:0] {wrWait, wrWrite, wrFence, wrFlag, wrDone} writeStateT;
   typedef enum logic [1:0] {rdWait, rdRead, rdResp, rdDone} readStateT;
   typedef enum logic [1:0] {pollWait, pollRead, pollResp, pollDone} pollStateT;

endpackage
